// ==== vec_alu_pkg.sv ====
package vec_alu_pkg;

    ////////////////////////////////////////////////////////////
    // Vector word geometry
    ////////////////////////////////////////////////////////////

    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    ////////////////////////////////////////////////////////////
    // Operation and width codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        VADD, VSUB, VRSUB,
        VAND, VOR, VXOR,
        VSLL, VSRL, VSRA,
        VMSEQ, VMSNE, VMSLTU, VMSLT, VMSLEU, VMSLE, VMSGTU, VMSGT,
        VMINU, VMIN, VMAXU, VMAX
    } vec_op_e;

    // Code 2'b11 falls back to 32-bit elements
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vec_sew_e;

    // Result classes seen by the writeback mux
    typedef enum logic [2:0] {
        CLS_ADD,
        CLS_LOGIC,
        CLS_SHIFT,
        CLS_CMP,
        CLS_MINMAX
    } op_class_e;

    // Shift kinds, reused as logic op codes for the logic class
    localparam logic [1:0] SHIFT_SLL = 2'd0;
    localparam logic [1:0] SHIFT_SRL = 2'd1;
    localparam logic [1:0] SHIFT_SRA = 2'd2;
    localparam logic [1:0] LOGIC_AND = 2'd0;
    localparam logic [1:0] LOGIC_OR  = 2'd1;
    localparam logic [1:0] LOGIC_XOR = 2'd2;

    // Compare kinds, signedness travels separately
    localparam logic [2:0] CMP_EQ = 3'd0;
    localparam logic [2:0] CMP_NE = 3'd1;
    localparam logic [2:0] CMP_LT = 3'd2;
    localparam logic [2:0] CMP_LE = 3'd3;
    localparam logic [2:0] CMP_GT = 3'd4;

endpackage

// ==== vec_elem_pkg.sv ====
package vec_elem_pkg;

    ////////////////////////////////////////////////////////////
    // Lanes per element width
    ////////////////////////////////////////////////////////////

    localparam int LANES8  = vec_alu_pkg::VLEN / 8;
    localparam int LANES16 = vec_alu_pkg::VLEN / 16;
    localparam int LANES32 = vec_alu_pkg::VLEN / 32;

    ////////////////////////////////////////////////////////////
    // One register word, three element views
    ////////////////////////////////////////////////////////////

    // Lane 0 sits in the low bits in every view
    typedef union packed {
        logic [LANES8-1:0][7:0]   e8;
        logic [LANES16-1:0][15:0] e16;
        logic [LANES32-1:0][31:0] e32;
    } vec_word_u;

endpackage

// ==== vec_issue.sv ====
`timescale 1ns/1ns

module vec_issue (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          in_valid_i,
    input  vec_alu_pkg::vec_op_e          op_i,
    input  vec_alu_pkg::vec_sew_e         sew_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  vs1_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  vs2_i,
    output logic                          issue_valid_o,
    output vec_alu_pkg::op_class_e        op_class_o,
    output vec_alu_pkg::vec_sew_e         sew_o,
    output logic [vec_alu_pkg::VLEN-1:0]  opa_o,
    output logic [vec_alu_pkg::VLEN-1:0]  opb_o,
    output logic                          negate_o,
    output logic [1:0]                    shift_kind_o,
    output logic [2:0]                    cmp_kind_o,
    output logic                          is_signed_o,
    output logic                          select_max_o
);

    vec_alu_pkg::op_class_e op_class;
    logic                   negate;
    logic                   swap;
    logic [1:0]             shift_kind;
    logic [2:0]             cmp_kind;
    logic                   is_signed;
    logic                   select_max;

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        op_class   = vec_alu_pkg::CLS_ADD;
        negate     = 1'b0;
        swap       = 1'b0;
        shift_kind = vec_alu_pkg::SHIFT_SLL;
        cmp_kind   = vec_alu_pkg::CMP_EQ;
        is_signed  = 1'b0;
        select_max = 1'b0;
        case (op_i)
            vec_alu_pkg::VSUB:   negate = 1'b1;
            // Reverse subtract becomes vs2 - vs1
            vec_alu_pkg::VRSUB: begin
                negate = 1'b1;
                swap   = 1'b1;
            end
            vec_alu_pkg::VAND, vec_alu_pkg::VOR, vec_alu_pkg::VXOR: begin
                op_class = vec_alu_pkg::CLS_LOGIC;
                if (op_i == vec_alu_pkg::VOR) shift_kind = vec_alu_pkg::LOGIC_OR;
                if (op_i == vec_alu_pkg::VXOR) shift_kind = vec_alu_pkg::LOGIC_XOR;
            end
            vec_alu_pkg::VSLL, vec_alu_pkg::VSRL, vec_alu_pkg::VSRA: begin
                op_class = vec_alu_pkg::CLS_SHIFT;
                if (op_i == vec_alu_pkg::VSRL) shift_kind = vec_alu_pkg::SHIFT_SRL;
                if (op_i == vec_alu_pkg::VSRA) shift_kind = vec_alu_pkg::SHIFT_SRA;
            end
            vec_alu_pkg::VMSEQ:  op_class = vec_alu_pkg::CLS_CMP;
            vec_alu_pkg::VMSNE: begin
                op_class = vec_alu_pkg::CLS_CMP;
                cmp_kind = vec_alu_pkg::CMP_NE;
            end
            vec_alu_pkg::VMSLTU, vec_alu_pkg::VMSLT: begin
                op_class  = vec_alu_pkg::CLS_CMP;
                cmp_kind  = vec_alu_pkg::CMP_LT;
                is_signed = (op_i == vec_alu_pkg::VMSLT);
            end
            vec_alu_pkg::VMSLEU, vec_alu_pkg::VMSLE: begin
                op_class  = vec_alu_pkg::CLS_CMP;
                cmp_kind  = vec_alu_pkg::CMP_LE;
                is_signed = (op_i == vec_alu_pkg::VMSLE);
            end
            vec_alu_pkg::VMSGTU, vec_alu_pkg::VMSGT: begin
                op_class  = vec_alu_pkg::CLS_CMP;
                cmp_kind  = vec_alu_pkg::CMP_GT;
                is_signed = (op_i == vec_alu_pkg::VMSGT);
            end
            vec_alu_pkg::VMINU, vec_alu_pkg::VMIN, vec_alu_pkg::VMAXU, vec_alu_pkg::VMAX: begin
                op_class   = vec_alu_pkg::CLS_MINMAX;
                is_signed  = (op_i == vec_alu_pkg::VMIN) || (op_i == vec_alu_pkg::VMAX);
                select_max = (op_i == vec_alu_pkg::VMAXU) || (op_i == vec_alu_pkg::VMAX);
            end
            default: op_class = vec_alu_pkg::CLS_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Stage buffer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid_o <= 1'b0;
            op_class_o    <= vec_alu_pkg::CLS_ADD;
            sew_o         <= vec_alu_pkg::EW8;
            negate_o      <= 1'b0;
            shift_kind_o  <= '0;
            cmp_kind_o    <= '0;
            is_signed_o   <= 1'b0;
            select_max_o  <= 1'b0;
        end else begin
            issue_valid_o <= in_valid_i;
            if (in_valid_i) begin
                op_class_o   <= op_class;
                sew_o        <= sew_i;
                negate_o     <= negate;
                shift_kind_o <= shift_kind;
                cmp_kind_o   <= cmp_kind;
                is_signed_o  <= is_signed;
                select_max_o <= select_max;
            end
        end
    end

    // Operand words
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            opa_o <= swap ? vs2_i : vs1_i;
            opb_o <= swap ? vs1_i : vs2_i;
        end
    end

endmodule

// ==== vec_add_shift.sv ====
`timescale 1ns/1ns

module vec_add_shift (
    input  vec_alu_pkg::vec_sew_e         sew_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  opa_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  opb_i,
    input  logic                          negate_i,
    input  logic [1:0]                    shift_kind_i,
    input  vec_alu_pkg::op_class_e        op_class_i,
    output logic [vec_alu_pkg::VLEN-1:0]  arith_result_o
);

    vec_elem_pkg::vec_word_u a;
    vec_elem_pkg::vec_word_u b;
    vec_elem_pkg::vec_word_u sum;
    vec_elem_pkg::vec_word_u shf;

    assign a = opa_i;
    assign b = opb_i;

    ////////////////////////////////////////////////////////////
    // Segmented add/sub and shifts
    ////////////////////////////////////////////////////////////

    // Each lane is sized to its element, so carries stop at the boundary
    always_comb begin
        sum = '0;
        shf = '0;
        case (sew_i)
            vec_alu_pkg::EW8: begin
                for (int i = 0; i < vec_elem_pkg::LANES8; i++) begin
                    sum.e8[i] = negate_i ? a.e8[i] - b.e8[i] : a.e8[i] + b.e8[i];
                    if (shift_kind_i == vec_alu_pkg::SHIFT_SRA)
                        shf.e8[i] = $signed(a.e8[i]) >>> b.e8[i][2:0];
                    else if (shift_kind_i == vec_alu_pkg::SHIFT_SRL)
                        shf.e8[i] = a.e8[i] >> b.e8[i][2:0];
                    else
                        shf.e8[i] = a.e8[i] << b.e8[i][2:0];
                end
            end
            vec_alu_pkg::EW16: begin
                for (int i = 0; i < vec_elem_pkg::LANES16; i++) begin
                    sum.e16[i] = negate_i ? a.e16[i] - b.e16[i] : a.e16[i] + b.e16[i];
                    if (shift_kind_i == vec_alu_pkg::SHIFT_SRA)
                        shf.e16[i] = $signed(a.e16[i]) >>> b.e16[i][3:0];
                    else if (shift_kind_i == vec_alu_pkg::SHIFT_SRL)
                        shf.e16[i] = a.e16[i] >> b.e16[i][3:0];
                    else
                        shf.e16[i] = a.e16[i] << b.e16[i][3:0];
                end
            end
            default: begin
                for (int i = 0; i < vec_elem_pkg::LANES32; i++) begin
                    sum.e32[i] = negate_i ? a.e32[i] - b.e32[i] : a.e32[i] + b.e32[i];
                    if (shift_kind_i == vec_alu_pkg::SHIFT_SRA)
                        shf.e32[i] = $signed(a.e32[i]) >>> b.e32[i][4:0];
                    else if (shift_kind_i == vec_alu_pkg::SHIFT_SRL)
                        shf.e32[i] = a.e32[i] >> b.e32[i][4:0];
                    else
                        shf.e32[i] = a.e32[i] << b.e32[i][4:0];
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Unit output select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_class_i)
            vec_alu_pkg::CLS_LOGIC: begin
                // Bitwise ops ignore element width
                case (shift_kind_i)
                    vec_alu_pkg::LOGIC_OR:  arith_result_o = opa_i | opb_i;
                    vec_alu_pkg::LOGIC_XOR: arith_result_o = opa_i ^ opb_i;
                    default:                arith_result_o = opa_i & opb_i;
                endcase
            end
            vec_alu_pkg::CLS_SHIFT: arith_result_o = shf;
            default:                arith_result_o = sum;
        endcase
    end

endmodule

// ==== vec_compare.sv ====
`timescale 1ns/1ns

module vec_compare (
    input  vec_alu_pkg::vec_sew_e         sew_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  opa_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  opb_i,
    input  logic [2:0]                    cmp_kind_i,
    input  logic                          is_signed_i,
    input  logic                          select_max_i,
    output logic [vec_alu_pkg::VLEN-1:0]  mask_o,
    output logic [vec_alu_pkg::VLEN-1:0]  minmax_o
);

    vec_elem_pkg::vec_word_u         a;
    vec_elem_pkg::vec_word_u         b;
    vec_elem_pkg::vec_word_u         mm;
    logic [vec_alu_pkg::VLENB-1:0]   eq;
    logic [vec_alu_pkg::VLENB-1:0]   gt;
    logic [vec_alu_pkg::VLENB-1:0]   lane_en;
    logic [vec_alu_pkg::VLENB-1:0]   flags;

    assign a = opa_i;
    assign b = opb_i;

    ////////////////////////////////////////////////////////////
    // Per-lane flags and min/max
    ////////////////////////////////////////////////////////////

    // Min/max reuses gt: take a when gt matches the wanted direction
    always_comb begin
        eq = '0;
        gt = '0;
        mm = '0;
        case (sew_i)
            vec_alu_pkg::EW8: begin
                lane_en = '1;
                for (int i = 0; i < vec_elem_pkg::LANES8; i++) begin
                    eq[i] = a.e8[i] == b.e8[i];
                    gt[i] = is_signed_i ? $signed(a.e8[i]) > $signed(b.e8[i])
                                        : a.e8[i] > b.e8[i];
                    mm.e8[i] = (gt[i] == select_max_i) ? a.e8[i] : b.e8[i];
                end
            end
            vec_alu_pkg::EW16: begin
                lane_en = vec_alu_pkg::VLENB'((1 << vec_elem_pkg::LANES16) - 1);
                for (int i = 0; i < vec_elem_pkg::LANES16; i++) begin
                    eq[i] = a.e16[i] == b.e16[i];
                    gt[i] = is_signed_i ? $signed(a.e16[i]) > $signed(b.e16[i])
                                        : a.e16[i] > b.e16[i];
                    mm.e16[i] = (gt[i] == select_max_i) ? a.e16[i] : b.e16[i];
                end
            end
            default: begin
                lane_en = vec_alu_pkg::VLENB'((1 << vec_elem_pkg::LANES32) - 1);
                for (int i = 0; i < vec_elem_pkg::LANES32; i++) begin
                    eq[i] = a.e32[i] == b.e32[i];
                    gt[i] = is_signed_i ? $signed(a.e32[i]) > $signed(b.e32[i])
                                        : a.e32[i] > b.e32[i];
                    mm.e32[i] = (gt[i] == select_max_i) ? a.e32[i] : b.e32[i];
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Compare mask
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cmp_kind_i)
            vec_alu_pkg::CMP_NE: flags = ~eq;
            vec_alu_pkg::CMP_LT: flags = ~eq & ~gt;
            vec_alu_pkg::CMP_LE: flags = eq | ~gt;
            vec_alu_pkg::CMP_GT: flags = gt;
            default:             flags = eq;
        endcase
    end

    // Lanes past the element count read as zero
    assign mask_o   = {{(vec_alu_pkg::VLEN - vec_alu_pkg::VLENB){1'b0}}, flags & lane_en};
    assign minmax_o = mm;

endmodule

// ==== vec_writeback.sv ====
`timescale 1ns/1ns

module vec_writeback (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          issue_valid_i,
    input  vec_alu_pkg::op_class_e        op_class_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  arith_result_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  mask_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  minmax_i,
    output logic [vec_alu_pkg::VLEN-1:0]  result_o,
    output logic                          valid_o
);

    logic [vec_alu_pkg::VLEN-1:0] result_sel;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op_class_i)
            vec_alu_pkg::CLS_CMP:    result_sel = mask_i;
            vec_alu_pkg::CLS_MINMAX: result_sel = minmax_i;
            default:                 result_sel = arith_result_i;
        endcase
    end

    // Output register, loaded only for a live item
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= issue_valid_i;
            if (issue_valid_i) begin
                result_o <= result_sel;
            end
        end
    end

endmodule

// ==== vec_alu_top.sv ====
`timescale 1ns/1ns

module vec_alu_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          in_valid_i,
    input  vec_alu_pkg::vec_op_e          op_i,
    input  vec_alu_pkg::vec_sew_e         sew_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  vs1_i,
    input  logic [vec_alu_pkg::VLEN-1:0]  vs2_i,
    output logic [vec_alu_pkg::VLEN-1:0]  result_o,
    output logic                          valid_o
);

    // Buffered controls
    logic                         issue_valid;
    vec_alu_pkg::op_class_e       op_class;
    vec_alu_pkg::vec_sew_e        sew;
    logic [vec_alu_pkg::VLEN-1:0] opa;
    logic [vec_alu_pkg::VLEN-1:0] opb;
    logic                         negate;
    logic [1:0]                   shift_kind;
    logic [2:0]                   cmp_kind;
    logic                         is_signed;
    logic                         select_max;

    // Unit outputs
    logic [vec_alu_pkg::VLEN-1:0] arith_result;
    logic [vec_alu_pkg::VLEN-1:0] mask;
    logic [vec_alu_pkg::VLEN-1:0] minmax;

    vec_issue u_issue (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_valid_i    (in_valid_i),
        .op_i          (op_i),
        .sew_i         (sew_i),
        .vs1_i         (vs1_i),
        .vs2_i         (vs2_i),
        .issue_valid_o (issue_valid),
        .op_class_o    (op_class),
        .sew_o         (sew),
        .opa_o         (opa),
        .opb_o         (opb),
        .negate_o      (negate),
        .shift_kind_o  (shift_kind),
        .cmp_kind_o    (cmp_kind),
        .is_signed_o   (is_signed),
        .select_max_o  (select_max)
    );

    vec_add_shift u_add_shift (
        .sew_i          (sew),
        .opa_i          (opa),
        .opb_i          (opb),
        .negate_i       (negate),
        .shift_kind_i   (shift_kind),
        .op_class_i     (op_class),
        .arith_result_o (arith_result)
    );

    vec_compare u_compare (
        .sew_i        (sew),
        .opa_i        (opa),
        .opb_i        (opb),
        .cmp_kind_i   (cmp_kind),
        .is_signed_i  (is_signed),
        .select_max_i (select_max),
        .mask_o       (mask),
        .minmax_o     (minmax)
    );

    vec_writeback u_writeback (
        .clk            (clk),
        .reset_n        (reset_n),
        .issue_valid_i  (issue_valid),
        .op_class_i     (op_class),
        .arith_result_i (arith_result),
        .mask_i         (mask),
        .minmax_i       (minmax),
        .result_o       (result_o),
        .valid_o        (valid_o)
    );

endmodule

// ==== vec_alu_assertions.sv ====
`timescale 1ns/1ns

module vec_alu_assertions (
    input logic                          clk,
    input logic                          reset_n,
    input logic                          in_valid_i,
    input vec_alu_pkg::vec_op_e          op_i,
    input logic [vec_alu_pkg::VLEN-1:0]  result_o,
    input logic                          valid_o
);

    int   fail_count = 0;
    logic is_cmp;

    assign is_cmp = (op_i >= vec_alu_pkg::VMSEQ) && (op_i <= vec_alu_pkg::VMSGT);

    ////////////////////////////////////////////////////////////
    // Output timing
    ////////////////////////////////////////////////////////////

    a_valid_after_strobe: assert property (
        @(posedge clk) disable iff (!reset_n) in_valid_i |-> ##2 valid_o
    ) else begin
        fail_count++;
        $error("valid_o missing two cycles after in_valid_i");
    end

    a_no_stray_valid: assert property (
        @(posedge clk) disable iff (!reset_n) valid_o |-> $past(in_valid_i, 2)
    ) else begin
        fail_count++;
        $error("valid_o high without a strobe two cycles before");
    end

    // Output register held clear during reset
    a_reset_quiet: assert property (
        @(posedge clk) !reset_n |-> !valid_o
    ) else begin
        fail_count++;
        $error("valid_o high while reset_n is low");
    end

    ////////////////////////////////////////////////////////////
    // Compare mask width
    ////////////////////////////////////////////////////////////

    a_mask_upper_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        in_valid_i && is_cmp |-> ##2 (result_o[vec_alu_pkg::VLEN-1:vec_alu_pkg::VLENB] == '0)
    ) else begin
        fail_count++;
        $error("compare result has bits set above the lane mask");
    end

endmodule

bind vec_alu_top vec_alu_assertions u_assertions (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_valid_i (in_valid_i),
    .op_i       (op_i),
    .result_o   (result_o),
    .valid_o    (valid_o)
);

// ==== tb_vec_alu.sv ====
`timescale 1ns/1ns

module tb_vec_alu;

    localparam int VLEN = vec_alu_pkg::VLEN;
    localparam int NUM_OPS = 21;
    localparam int NUM_RANDOM = 64;
    // Shared compare operands with lanes 7..0 in byte order
    localparam logic [VLEN-1:0] CMP_A = 64'h8001_7FFF_0005_05FE;
    localparam logic [VLEN-1:0] CMP_B = 64'h0180_7F01_0004_06FE;

    logic                  clk;
    logic                  reset_n;
    logic                  in_valid_i;
    vec_alu_pkg::vec_op_e  op_i;
    vec_alu_pkg::vec_sew_e sew_i;
    logic [VLEN-1:0]       vs1_i;
    logic [VLEN-1:0]       vs2_i;
    logic [VLEN-1:0]       result_o;
    logic                  valid_o;

    // Stimulus table
    string                 tab_name[$];
    vec_alu_pkg::vec_op_e  tab_op[$];
    vec_alu_pkg::vec_sew_e tab_sew[$];
    logic [VLEN-1:0]       tab_vs1[$];
    logic [VLEN-1:0]       tab_vs2[$];
    logic [VLEN-1:0]       tab_exp[$];

    // Results in flight with the oldest first
    string                 pend_name[$];
    logic [VLEN-1:0]       pend_exp[$];
    int                    pend_due[$];

    int                    cycle;
    int                    errors;
    int                    checks;
    logic [31:0]           rng_state;

    vec_alu_top UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid_i (in_valid_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .vs1_i      (vs1_i),
        .vs2_i      (vs2_i),
        .result_o   (result_o),
        .valid_o    (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Lane-wise model of vs1 op vs2 per element
    function automatic logic [VLEN-1:0] ref_result(input vec_alu_pkg::vec_op_e op,
                                                   input vec_alu_pkg::vec_sew_e sew,
                                                   input logic [VLEN-1:0] x,
                                                   input logic [VLEN-1:0] y);
        int              w;
        int              sh;
        longint          ea;
        longint          eb;
        longint          sa;
        longint          sb;
        longint          r;
        longint          m;
        logic [VLEN-1:0] res;
        w = (sew == vec_alu_pkg::EW8) ? 8 : (sew == vec_alu_pkg::EW16) ? 16 : 32;
        m = (longint'(1) << w) - 1;
        res = '0;
        for (int i = 0; i < VLEN / w; i++) begin
            ea = longint'(x >> (i * w)) & m;
            eb = longint'(y >> (i * w)) & m;
            sa = (ea > m / 2) ? ea - (m + 1) : ea;
            sb = (eb > m / 2) ? eb - (m + 1) : eb;
            sh = int'(eb % w);
            r = 0;
            case (op)
                vec_alu_pkg::VADD:   r = ea + eb;
                vec_alu_pkg::VSUB:   r = ea - eb;
                vec_alu_pkg::VRSUB:  r = eb - ea;
                vec_alu_pkg::VAND:   r = ea & eb;
                vec_alu_pkg::VOR:    r = ea | eb;
                vec_alu_pkg::VXOR:   r = ea ^ eb;
                vec_alu_pkg::VSLL:   r = ea << sh;
                vec_alu_pkg::VSRL:   r = ea >> sh;
                vec_alu_pkg::VSRA:   r = sa >>> sh;
                vec_alu_pkg::VMSEQ:  res[i] = (ea == eb);
                vec_alu_pkg::VMSNE:  res[i] = (ea != eb);
                vec_alu_pkg::VMSLTU: res[i] = (ea < eb);
                vec_alu_pkg::VMSLT:  res[i] = (sa < sb);
                vec_alu_pkg::VMSLEU: res[i] = (ea <= eb);
                vec_alu_pkg::VMSLE:  res[i] = (sa <= sb);
                vec_alu_pkg::VMSGTU: res[i] = (ea > eb);
                vec_alu_pkg::VMSGT:  res[i] = (sa > sb);
                vec_alu_pkg::VMINU:  r = (ea < eb) ? ea : eb;
                vec_alu_pkg::VMIN:   r = (sa < sb) ? ea : eb;
                vec_alu_pkg::VMAXU:  r = (ea > eb) ? ea : eb;
                vec_alu_pkg::VMAX:   r = (sa > sb) ? ea : eb;
                default:             r = 0;
            endcase
            // Compares leave r at zero
            res = res | (VLEN'(r & m) << (i * w));
        end
        return res;
    endfunction

    task automatic add_case(input string name, input vec_alu_pkg::vec_op_e op,
                            input vec_alu_pkg::vec_sew_e sew, input logic [VLEN-1:0] a,
                            input logic [VLEN-1:0] b, input logic [VLEN-1:0] expected);
        tab_name.push_back(name);
        tab_op.push_back(op);
        tab_sew.push_back(sew);
        tab_vs1.push_back(a);
        tab_vs2.push_back(b);
        tab_exp.push_back(expected);
    endtask

    task automatic check_value(input string name, input logic [VLEN-1:0] expected,
                               input logic [VLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Called 1 ns after a rising edge with the result due two edges later
    task automatic send_op(input string name, input vec_alu_pkg::vec_op_e op,
                           input vec_alu_pkg::vec_sew_e sew, input logic [VLEN-1:0] a,
                           input logic [VLEN-1:0] b, input logic [VLEN-1:0] expected);
        in_valid_i = 1'b1;
        op_i = op;
        sew_i = sew;
        vs1_i = a;
        vs2_i = b;
        pend_name.push_back(name);
        pend_exp.push_back(expected);
        pend_due.push_back(cycle + 2);
    endtask

    ////////////////////////////////////////////////////////////
    // Result monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (reset_n && valid_o) begin
            if (pend_exp.size() == 0) begin
                errors++;
                $display("valid_o went high at cycle %0d with nothing pending", cycle);
            end else begin
                if (pend_due[0] != cycle) begin
                    errors++;
                    $display("%s arrived at cycle %0d, due at cycle %0d",
                             pend_name[0], cycle, pend_due[0]);
                end
                check_value(pend_name[0], pend_exp[0], result_o);
                void'(pend_name.pop_front());
                void'(pend_exp.pop_front());
                void'(pend_due.pop_front());
            end
        end else if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
            errors++;
            $display("%s produced no valid_o at cycle %0d", pend_name[0], cycle);
            void'(pend_name.pop_front());
            void'(pend_exp.pop_front());
            void'(pend_due.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [VLEN-1:0]       a;
        logic [VLEN-1:0]       b;
        vec_alu_pkg::vec_op_e  op;
        vec_alu_pkg::vec_sew_e sew;
        int                    t;
        cycle = 0;
        errors = 0;
        checks = 0;
        rng_state = 32'd88160;
        reset_n = 1'b0;
        in_valid_i = 1'b0;
        op_i = vec_alu_pkg::VADD;
        sew_i = vec_alu_pkg::EW8;
        vs1_i = '0;
        vs2_i = '0;

        // Carries and borrows stop at element edges
        add_case("add8_wrap", vec_alu_pkg::VADD, vec_alu_pkg::EW8,
                 64'hFF01_7F80_0000_10FF, 64'h0101_0180_0000_F001, 64'h0002_8000_0000_0000);
        add_case("add16_wrap", vec_alu_pkg::VADD, vec_alu_pkg::EW16,
                 64'hFFFF_0001_8000_1234, 64'h0001_FFFF_8000_0001, 64'h0000_0000_0000_1235);
        add_case("add32_wrap", vec_alu_pkg::VADD, vec_alu_pkg::EW32,
                 64'hFFFF_FFFF_7FFF_FFFF, 64'h0000_0001_0000_0001, 64'h0000_0000_8000_0000);
        add_case("sub8_borrow", vec_alu_pkg::VSUB, vec_alu_pkg::EW8,
                 64'h0000_0000_0000_0100, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_01FF);
        add_case("rsub16", vec_alu_pkg::VRSUB, vec_alu_pkg::EW16,
                 64'h0001_0000_0000_0005, 64'h0000_0000_0000_0003, 64'hFFFF_0000_0000_FFFE);
        add_case("and32", vec_alu_pkg::VAND, vec_alu_pkg::EW32,
                 64'hF0F0_FF00_1234_5678, 64'h0FF0_0FF0_FFFF_0000, 64'h00F0_0F00_1234_0000);
        add_case("or8", vec_alu_pkg::VOR, vec_alu_pkg::EW8,
                 64'hF0F0_FF00_1234_5678, 64'h0FF0_0FF0_FFFF_0000, 64'hFFF0_FFF0_FFFF_5678);
        add_case("xor16", vec_alu_pkg::VXOR, vec_alu_pkg::EW16,
                 64'hF0F0_FF00_1234_5678, 64'h0FF0_0FF0_FFFF_0000, 64'hFF00_F0F0_EDCB_5678);
        // Shift amounts wrap at the element width
        add_case("sll8_mod", vec_alu_pkg::VSLL, vec_alu_pkg::EW8,
                 64'h0101_0101_0101_0101, 64'h0001_0708_090F_1011, 64'h0102_8001_0280_0102);
        add_case("srl16_mod", vec_alu_pkg::VSRL, vec_alu_pkg::EW16,
                 64'h8000_8000_8000_8000, 64'h0000_000F_0010_0011, 64'h8000_0001_8000_4000);
        add_case("sra32_mod", vec_alu_pkg::VSRA, vec_alu_pkg::EW32,
                 64'h8000_0000_4000_0000, 64'h0000_0004_0000_0021, 64'hF800_0000_2000_0000);
        add_case("sra8_sign", vec_alu_pkg::VSRA, vec_alu_pkg::EW8,
                 64'h80FF_7F01_8080_C000, 64'h0707_0701_0109_0102, 64'hFFFF_0000_C0C0_E000);
        add_case("seq8", vec_alu_pkg::VMSEQ, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h29);
        add_case("sne8", vec_alu_pkg::VMSNE, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'hD6);
        add_case("sltu8", vec_alu_pkg::VMSLTU, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h42);
        add_case("slt8", vec_alu_pkg::VMSLT, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h92);
        add_case("sleu8", vec_alu_pkg::VMSLEU, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h6B);
        add_case("sle8", vec_alu_pkg::VMSLE, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'hBB);
        add_case("sgtu8", vec_alu_pkg::VMSGTU, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h94);
        add_case("sgt8", vec_alu_pkg::VMSGT, vec_alu_pkg::EW8, CMP_A, CMP_B, 64'h44);
        add_case("sltu16", vec_alu_pkg::VMSLTU, vec_alu_pkg::EW16, CMP_A, CMP_B, 64'h01);
        add_case("slt16", vec_alu_pkg::VMSLT, vec_alu_pkg::EW16, CMP_A, CMP_B, 64'h09);
        add_case("minu8", vec_alu_pkg::VMINU, vec_alu_pkg::EW8,
                 CMP_A, CMP_B, 64'h0101_7F01_0004_05FE);
        add_case("min8", vec_alu_pkg::VMIN, vec_alu_pkg::EW8,
                 CMP_A, CMP_B, 64'h8080_7FFF_0004_05FE);
        add_case("maxu8", vec_alu_pkg::VMAXU, vec_alu_pkg::EW8,
                 CMP_A, CMP_B, 64'h8080_7FFF_0005_06FE);
        add_case("max8", vec_alu_pkg::VMAX, vec_alu_pkg::EW8,
                 CMP_A, CMP_B, 64'h0101_7F01_0005_06FE);

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // Monitor flags any stray valid_o while idle
        repeat (4) @(posedge clk);
        #1;
        // Output register still holds its reset value
        check_value("reset_result", '0, result_o);

        for (int i = 0; i < tab_name.size(); i++) begin
            @(posedge clk);
            #1;
            send_op(tab_name[i], tab_op[i], tab_sew[i], tab_vs1[i], tab_vs2[i], tab_exp[i]);
        end

        // Random back-to-back traffic including width code 3
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = {next_random(), next_random()};
            b = {next_random(), next_random()};
            op = vec_alu_pkg::vec_op_e'(next_random() % NUM_OPS);
            sew = vec_alu_pkg::vec_sew_e'(next_random() & 32'h3);
            @(posedge clk);
            #1;
            send_op($sformatf("random_%0d_%s", i, op.name()), op, sew, a, b,
                    ref_result(op, sew, a, b));
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;

        t = 0;
        while (pend_exp.size() > 0 && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (pend_exp.size() > 0) begin
            errors++;
            $display("Timed out with %0d results still pending", pend_exp.size());
        end
        repeat (2) @(posedge clk);

        errors += UUT.u_assertions.fail_count;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
vec_alu_pkg.sv
vec_elem_pkg.sv
vec_issue.sv
vec_add_shift.sv
vec_compare.sv
vec_writeback.sv
vec_alu_top.sv
vec_alu_assertions.sv
tb_vec_alu.sv
